/* common/cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;
    localparam int exccode_w  = 5;

    localparam logic [exccode_w-1:0]  ex_sys   = 5'd8;
    localparam logic [exccode_w-1:0]  ex_bp    = 5'd9;
    localparam logic [exccode_w-1:0]  ex_ri    = 5'd10;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_sra     = 6'h03;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_jalr    = 6'h09;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_break   = 6'h0d;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;
    localparam logic [5:0] fn_sltu    = 6'h2b;

    // regimm rt field
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    // bit positions in the one-hot alu vector
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_bgez, br_bgtz, br_blez,
        br_bltz, br_j, br_jal, br_jr, br_jalr
    } br_kind_e;

    typedef struct packed {
        logic                 ex;
        logic [exccode_w-1:0] exccode;
        logic [xlen-1:0]      badvaddr;
        logic [xlen-1:0]      inst;
        logic [xlen-1:0]      pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic [alu_op_w-1:0]   alu_op;
        logic                  load_op;
        logic                  mem_we;
        logic                  gr_we;
        logic                  ov_op;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_signed_imm;
        logic                  src2_is_zero_imm;
        logic                  src2_is_8;
        logic [reg_addr_w-1:0] dest;
        br_kind_e              br_kind;
        logic                  ex_ri;
        logic                  ex_bp;
        logic                  ex_sys;
    } ds_ctrl_t;

    typedef struct packed {
        logic                  ex;
        logic [exccode_w-1:0]  exccode;
        logic [xlen-1:0]       badvaddr;
        logic                  ov_op;
        logic [alu_op_w-1:0]   alu_op;
        logic                  load_op;
        logic                  mem_we;
        logic                  src1_is_sa;
        logic                  src1_is_pc;
        logic                  src2_is_signed_imm;
        logic                  src2_is_zero_imm;
        logic                  src2_is_8;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [15:0]           imm;
        logic [xlen-1:0]       rs_value;
        logic [xlen-1:0]       rt_value;
        logic [xlen-1:0]       pc;
    } ds_to_es_t;

    // is_load only meaningful on the execute source
    typedef struct packed {
        logic                  valid;
        logic                  gr_we;
        logic                  is_load;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       result;
    } fwd_src_t;

    typedef struct packed {
        logic            op;
        logic            taken;
        logic [xlen-1:0] target;
    } br_t;

endpackage

/* rtl/reg_file.sv */
module reg_file (
    input  logic                           clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [cpu_pkg::xlen-1:0]       rdata1,
    output logic [cpu_pkg::xlen-1:0]       rdata2,
    input  cpu_pkg::fwd_src_t              wb
);
    import cpu_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (wb.valid && wb.gr_we) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // r0 is hardwired to zero on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* decode/inst_decoder.sv */
module inst_decoder (
    input  logic [cpu_pkg::xlen-1:0] inst,
    output cpu_pkg::ds_ctrl_t        ctrl
);
    import cpu_pkg::*;

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       is_special;
    logic       r_arith;
    logic       inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor, inst_sll, inst_srl, inst_sra;
    logic       inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_j, inst_jal, inst_jr, inst_jalr, inst_syscall, inst_break;
    logic       dst_is_rt;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    assign is_special = (op == op_special);
    // three-register forms need sa clear
    assign r_arith    = is_special && (sa == 5'd0);

    assign inst_add     = r_arith && (func == fn_add);
    assign inst_addu    = r_arith && (func == fn_addu);
    assign inst_sub     = r_arith && (func == fn_sub);
    assign inst_subu    = r_arith && (func == fn_subu);
    assign inst_slt     = r_arith && (func == fn_slt);
    assign inst_sltu    = r_arith && (func == fn_sltu);
    assign inst_and     = r_arith && (func == fn_and);
    assign inst_or      = r_arith && (func == fn_or);
    assign inst_xor     = r_arith && (func == fn_xor);
    assign inst_nor     = r_arith && (func == fn_nor);
    assign inst_sll     = is_special && (rs == 5'd0) && (func == fn_sll);
    assign inst_srl     = is_special && (rs == 5'd0) && (func == fn_srl);
    assign inst_sra     = is_special && (rs == 5'd0) && (func == fn_sra);
    assign inst_jr      = r_arith && (rt == 5'd0) && (rd == 5'd0) && (func == fn_jr);
    assign inst_jalr    = r_arith && (rt == 5'd0) && (func == fn_jalr);
    assign inst_syscall = is_special && (func == fn_syscall);
    assign inst_break   = is_special && (func == fn_break);

    assign inst_addi  = (op == op_addi);
    assign inst_addiu = (op == op_addiu);
    assign inst_slti  = (op == op_slti);
    assign inst_sltiu = (op == op_sltiu);
    assign inst_andi  = (op == op_andi);
    assign inst_ori   = (op == op_ori);
    assign inst_xori  = (op == op_xori);
    assign inst_lui   = (op == op_lui) && (rs == 5'd0);
    assign inst_lw    = (op == op_lw);
    assign inst_sw    = (op == op_sw);
    assign inst_beq   = (op == op_beq);
    assign inst_bne   = (op == op_bne);
    assign inst_bgez  = (op == op_regimm) && (rt == rt_bgez);
    assign inst_bltz  = (op == op_regimm) && (rt == rt_bltz);
    assign inst_bgtz  = (op == op_bgtz) && (rt == 5'd0);
    assign inst_blez  = (op == op_blez) && (rt == 5'd0);
    assign inst_j     = (op == op_j);
    assign inst_jal   = (op == op_jal);

    assign dst_is_rt = inst_addi | inst_addiu | inst_slti | inst_sltiu | inst_andi
                     | inst_ori | inst_xori | inst_lui | inst_lw;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[alu_add]  = inst_add | inst_addu | inst_addi | inst_addiu
                              | inst_lw | inst_sw | inst_jal | inst_jalr;
        ctrl.alu_op[alu_sub]  = inst_sub | inst_subu;
        ctrl.alu_op[alu_slt]  = inst_slt | inst_slti;
        ctrl.alu_op[alu_sltu] = inst_sltu | inst_sltiu;
        ctrl.alu_op[alu_and]  = inst_and | inst_andi;
        ctrl.alu_op[alu_nor]  = inst_nor;
        ctrl.alu_op[alu_or]   = inst_or | inst_ori;
        ctrl.alu_op[alu_xor]  = inst_xor | inst_xori;
        ctrl.alu_op[alu_sll]  = inst_sll;
        ctrl.alu_op[alu_srl]  = inst_srl;
        ctrl.alu_op[alu_sra]  = inst_sra;
        ctrl.alu_op[alu_lui]  = inst_lui;

        ctrl.load_op            = inst_lw;
        ctrl.mem_we             = inst_sw;
        ctrl.ov_op              = inst_add | inst_addi | inst_sub;
        ctrl.src1_is_sa         = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc         = inst_jal | inst_jalr;
        ctrl.src2_is_signed_imm = inst_addi | inst_addiu | inst_slti | inst_sltiu
                                | inst_lui | inst_lw | inst_sw;
        ctrl.src2_is_zero_imm   = inst_andi | inst_ori | inst_xori;
        ctrl.src2_is_8          = inst_jal | inst_jalr;
        ctrl.gr_we              = (|ctrl.alu_op) & ~inst_sw;
        ctrl.dest               = inst_jal ? link_reg : (dst_is_rt ? rt : rd);

        if (inst_beq)       ctrl.br_kind = br_beq;
        else if (inst_bne)  ctrl.br_kind = br_bne;
        else if (inst_bgez) ctrl.br_kind = br_bgez;
        else if (inst_bgtz) ctrl.br_kind = br_bgtz;
        else if (inst_blez) ctrl.br_kind = br_blez;
        else if (inst_bltz) ctrl.br_kind = br_bltz;
        else if (inst_j)    ctrl.br_kind = br_j;
        else if (inst_jal)  ctrl.br_kind = br_jal;
        else if (inst_jr)   ctrl.br_kind = br_jr;
        else if (inst_jalr) ctrl.br_kind = br_jalr;
        else                ctrl.br_kind = br_none;

        // anything not matched above is reserved
        ctrl.ex_ri  = ~((|ctrl.alu_op) | inst_beq | inst_bne | inst_bgez | inst_bgtz
                    | inst_blez | inst_bltz | inst_j | inst_jr | inst_syscall | inst_break);
        ctrl.ex_bp  = inst_break;
        ctrl.ex_sys = inst_syscall;
    end

endmodule

/* decode/operand_bypass.sv */
module operand_bypass (
    input  logic [cpu_pkg::reg_addr_w-1:0] rs,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt,
    input  logic [cpu_pkg::xlen-1:0]       rf_rs,
    input  logic [cpu_pkg::xlen-1:0]       rf_rt,
    input  cpu_pkg::fwd_src_t              es_fwd,
    input  cpu_pkg::fwd_src_t              ms_fwd,
    input  cpu_pkg::fwd_src_t              wb,
    output logic [cpu_pkg::xlen-1:0]       rs_value,
    output logic [cpu_pkg::xlen-1:0]       rt_value,
    output logic                           load_stall
);
    import cpu_pkg::*;

    // producer writes a live nonzero register equal to idx
    function automatic logic hit(input fwd_src_t src, input logic [reg_addr_w-1:0] idx);
        return src.valid && src.gr_we && (src.dest != '0) && (src.dest == idx);
    endfunction

    // youngest result wins
    assign rs_value = hit(es_fwd, rs) ? es_fwd.result :
                      hit(ms_fwd, rs) ? ms_fwd.result :
                      hit(wb, rs)     ? wb.result     :
                                        rf_rs;

    assign rt_value = hit(es_fwd, rt) ? es_fwd.result :
                      hit(ms_fwd, rt) ? ms_fwd.result :
                      hit(wb, rt)     ? wb.result     :
                                        rf_rt;

    // load data not ready until memory stage
    assign load_stall = es_fwd.valid && es_fwd.is_load && (es_fwd.dest != '0)
                     && ((es_fwd.dest == rs) || (es_fwd.dest == rt));

endmodule

/* decode/branch_unit.sv */
module branch_unit (
    input  logic                     valid,
    input  cpu_pkg::br_kind_e        kind,
    input  logic [cpu_pkg::xlen-1:0] inst,
    input  logic [cpu_pkg::xlen-1:0] pc,
    input  logic [cpu_pkg::xlen-1:0] rs_value,
    input  logic [cpu_pkg::xlen-1:0] rt_value,
    output cpu_pkg::br_t             br
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] br_offset;
    logic            rs_eq_rt;
    logic            rs_eq_zero;
    logic            rs_lt_zero;
    logic            cond;

    assign pc_plus4   = pc + 32'd4;
    assign br_offset  = {{14{inst[15]}}, inst[15:0], 2'b00};
    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_eq_zero = (rs_value == '0);
    assign rs_lt_zero = rs_value[xlen-1];

    always_comb begin
        case (kind)
            br_beq:  cond = rs_eq_rt;
            br_bne:  cond = !rs_eq_rt;
            br_bgez: cond = !rs_lt_zero;
            br_bgtz: cond = !rs_lt_zero && !rs_eq_zero;
            br_blez: cond = rs_lt_zero || rs_eq_zero;
            br_bltz: cond = rs_lt_zero;
            br_j, br_jal, br_jr, br_jalr: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    assign br.op    = valid && (kind != br_none);
    assign br.taken = valid && cond;
    assign br.target = (kind == br_jr || kind == br_jalr) ? rs_value :
                       (kind == br_j  || kind == br_jal)  ? {pc_plus4[31:28], inst[25:0], 2'b00} :
                                                            pc_plus4 + br_offset;

endmodule

/* decode/decode_stage.sv */
module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               fs_to_ds_valid,
    input  cpu_pkg::fs_to_ds_t fs_to_ds,
    output logic               ds_allowin,
    input  logic               es_allowin,
    output logic               ds_to_es_valid,
    output cpu_pkg::ds_to_es_t ds_to_es,
    input  cpu_pkg::fwd_src_t  es_fwd,
    input  cpu_pkg::fwd_src_t  ms_fwd,
    input  cpu_pkg::fwd_src_t  wb,
    output cpu_pkg::br_t       br
);
    import cpu_pkg::*;

    logic                  ds_valid;
    logic                  ready_go;
    logic                  load_stall;
    fs_to_ds_t             fs_r;
    ds_ctrl_t              ctrl;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [xlen-1:0]       rf_rs;
    logic [xlen-1:0]       rf_rt;
    logic [xlen-1:0]       rs_value;
    logic [xlen-1:0]       rt_value;

    assign rs = fs_r.inst[25:21];
    assign rt = fs_r.inst[20:16];

    // handshake
    assign ready_go       = !load_stall;
    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_r <= fs_to_ds;
        end
    end

    inst_decoder u_inst_decoder (
        .inst (fs_r.inst),
        .ctrl (ctrl)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wb     (wb)
    );

    operand_bypass u_operand_bypass (
        .rs         (rs),
        .rt         (rt),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .es_fwd     (es_fwd),
        .ms_fwd     (ms_fwd),
        .wb         (wb),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch_unit (
        .valid    (ds_valid),
        .kind     (ctrl.br_kind),
        .inst     (fs_r.inst),
        .pc       (fs_r.pc),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .br       (br)
    );

    always_comb begin
        ds_to_es.ex       = ds_valid && (fs_r.ex || ctrl.ex_ri || ctrl.ex_bp || ctrl.ex_sys);
        // fetch exception wins, then ri, bp, sys
        if (fs_r.ex) begin
            ds_to_es.exccode = fs_r.exccode;
        end else if (ctrl.ex_ri) begin
            ds_to_es.exccode = ex_ri;
        end else if (ctrl.ex_bp) begin
            ds_to_es.exccode = ex_bp;
        end else if (ctrl.ex_sys) begin
            ds_to_es.exccode = ex_sys;
        end else begin
            ds_to_es.exccode = '0;
        end
        ds_to_es.badvaddr           = fs_r.badvaddr;
        ds_to_es.ov_op              = ctrl.ov_op;
        ds_to_es.alu_op             = ctrl.alu_op;
        ds_to_es.load_op            = ctrl.load_op;
        ds_to_es.mem_we             = ctrl.mem_we;
        ds_to_es.src1_is_sa         = ctrl.src1_is_sa;
        ds_to_es.src1_is_pc         = ctrl.src1_is_pc;
        ds_to_es.src2_is_signed_imm = ctrl.src2_is_signed_imm;
        ds_to_es.src2_is_zero_imm   = ctrl.src2_is_zero_imm;
        ds_to_es.src2_is_8          = ctrl.src2_is_8;
        ds_to_es.gr_we              = ctrl.gr_we;
        ds_to_es.dest               = ctrl.dest;
        ds_to_es.imm                = fs_r.inst[15:0];
        ds_to_es.rs_value           = rs_value;
        ds_to_es.rt_value           = rt_value;
        ds_to_es.pc                 = fs_r.pc;
    end

endmodule

/* testbench/tb_tasks.svh */
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [4:0] sa,
                                      input logic [5:0] fn);
    return {op_special, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
endfunction

function automatic logic [31:0] branch_target(input logic [31:0] pc, input logic [15:0] off);
    return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
endfunction

function automatic logic [31:0] jump_target(input logic [31:0] pc, input logic [25:0] index);
    logic [31:0] next_pc;
    next_pc = pc + 32'd4;
    return {next_pc[31:28], index, 2'b00};
endfunction

function automatic fwd_src_t make_fwd(input logic valid, input logic is_load,
                                      input logic [4:0] dest, input logic [31:0] result);
    fwd_src_t f;
    f.valid   = valid;
    f.gr_we   = 1'b1;
    f.is_load = is_load;
    f.dest    = dest;
    f.result  = result;
    return f;
endfunction

function automatic fs_to_ds_t make_fetch(input logic ex, input logic [4:0] code,
                                         input logic [31:0] badvaddr,
                                         input logic [31:0] inst, input logic [31:0] pc);
    fs_to_ds_t f;
    f.ex       = ex;
    f.exccode  = code;
    f.badvaddr = badvaddr;
    f.inst     = inst;
    f.pc       = pc;
    return f;
endfunction

task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
    @(negedge clk);
    wb = make_fwd(1'b1, 1'b0, idx, value);
    @(posedge clk);
    @(negedge clk);
    wb = '0;
    if (idx != 5'd0) begin
        reg_model[idx] = value;
    end
endtask

// offer one item and hold it until the stage takes it
task automatic send(input fs_to_ds_t item);
    int waited;
    waited = 0;
    @(negedge clk);
    fs_to_ds_valid = 1'b1;
    fs_to_ds       = item;
    @(posedge clk);
    while (!ds_allowin) begin
        waited++;
        if (waited > wait_limit) begin
            $display("fetch item was never accepted by the decode stage");
            end_with_failure();
        end
        @(posedge clk);
    end
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
endtask

task automatic issue(input logic [31:0] inst, input logic [31:0] pc);
    send(make_fetch(1'b0, 5'd0, 32'h0, inst, pc));
endtask

// returns at the edge where the output is valid, values still pre-edge
task automatic await_output();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!ds_to_es_valid) begin
        waited++;
        if (waited > wait_limit) begin
            $display("decode stage never presented its item to execute");
            end_with_failure();
        end
        @(posedge clk);
    end
endtask

task automatic release_item();
    @(negedge clk);
    es_allowin = 1'b1;
    @(posedge clk);
endtask

task automatic test_reset_and_regs();
    logic [4:0] r;
    @(posedge clk);
    check_equal("ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_equal("br.op", br.op, 1'b0);
    check_equal("br.taken", br.taken, 1'b0);
    check_equal("ds_allowin", ds_allowin, 1'b1);
    for (r = 5'd1; r <= 5'd6; r++) begin
        write_reg(r, next_random());
    end
    for (r = 5'd1; r <= 5'd5; r++) begin
        issue(enc_r(r, r + 5'd1, 5'd7, 5'd0, fn_addu), 32'h0040_0000);
        await_output();
        check_equal("rs_value", ds_to_es.rs_value, reg_model[r]);
        check_equal("rt_value", ds_to_es.rt_value, reg_model[r + 5'd1]);
    end
    write_reg(5'd0, next_random());
    issue(enc_r(5'd0, 5'd0, 5'd7, 5'd0, fn_addu), 32'h0040_0004);
    await_output();
    check_equal("rs_value", ds_to_es.rs_value, 32'h0);
    check_equal("rt_value", ds_to_es.rt_value, 32'h0);
endtask

// flags are {ov, load, mem_we, gr_we, sa, pc, simm, zimm, src2_is_8}
task automatic decode_case(input logic [31:0] inst, input int alu_bit,
                           input logic [8:0] flags, input logic [4:0] dest);
    logic [alu_op_w-1:0] one_hot;
    one_hot          = '0;
    one_hot[alu_bit] = 1'b1;
    issue(inst, 32'h0040_0010);
    await_output();
    check_equal("alu_op", ds_to_es.alu_op, one_hot);
    check_equal("ctrl flags", {ds_to_es.ov_op, ds_to_es.load_op, ds_to_es.mem_we,
                               ds_to_es.gr_we, ds_to_es.src1_is_sa, ds_to_es.src1_is_pc,
                               ds_to_es.src2_is_signed_imm, ds_to_es.src2_is_zero_imm,
                               ds_to_es.src2_is_8}, flags);
    check_equal("dest", ds_to_es.dest, dest);
    check_equal("imm", ds_to_es.imm, inst[15:0]);
    check_equal("ex", ds_to_es.ex, 1'b0);
endtask

task automatic test_decode_fields();
    decode_case(enc_i(op_addiu, 5'd1, 5'd8, 16'h8004), alu_add, 9'b000100100, 5'd8);
    decode_case(enc_i(op_ori, 5'd2, 5'd9, 16'hf00f), alu_or, 9'b000100010, 5'd9);
    decode_case(enc_i(op_lui, 5'd0, 5'd10, 16'h1234), alu_lui, 9'b000100100, 5'd10);
    decode_case(enc_i(op_lw, 5'd3, 5'd11, 16'h0010), alu_add, 9'b010100100, 5'd11);
    decode_case(enc_i(op_sw, 5'd3, 5'd4, 16'h0024), alu_add, 9'b001000100, 5'd0);
    decode_case(enc_r(5'd0, 5'd5, 5'd12, 5'd7, fn_sll), alu_sll, 9'b000110000, 5'd12);
    decode_case(enc_r(5'd1, 5'd2, 5'd13, 5'd0, fn_sub), alu_sub, 9'b100100000, 5'd13);
    decode_case(enc_r(5'd1, 5'd2, 5'd14, 5'd0, fn_slt), alu_slt, 9'b000100000, 5'd14);
endtask

task automatic test_forwarding();
    logic [31:0] v_es;
    logic [31:0] v_ms;
    logic [31:0] v_wb;
    v_es = next_random();
    v_ms = next_random();
    v_wb = next_random();
    @(negedge clk);
    es_allowin = 1'b0;
    issue(enc_r(5'd3, 5'd4, 5'd15, 5'd0, fn_addu), 32'h0040_0020);
    await_output();
    @(negedge clk);
    es_fwd = make_fwd(1'b1, 1'b0, 5'd3, v_es);
    ms_fwd = make_fwd(1'b1, 1'b0, 5'd3, v_ms);
    wb     = make_fwd(1'b1, 1'b0, 5'd3, v_wb);
    @(posedge clk);
    check_equal("rs_value", ds_to_es.rs_value, v_es);
    @(negedge clk);
    es_fwd = '0;
    @(posedge clk);
    check_equal("rs_value", ds_to_es.rs_value, v_ms);
    @(negedge clk);
    ms_fwd = '0;
    @(posedge clk);
    check_equal("rs_value", ds_to_es.rs_value, v_wb);
    // wb also wrote the register file while it was valid
    @(negedge clk);
    wb           = '0;
    reg_model[3] = v_wb;
    @(posedge clk);
    check_equal("rs_value", ds_to_es.rs_value, reg_model[3]);
    check_equal("rt_value", ds_to_es.rt_value, reg_model[4]);
    release_item();
    @(negedge clk);
    es_fwd = make_fwd(1'b1, 1'b0, 5'd0, next_random());
    issue(enc_r(5'd0, 5'd5, 5'd16, 5'd0, fn_addu), 32'h0040_0024);
    await_output();
    check_equal("rs_value", ds_to_es.rs_value, 32'h0);
    check_equal("rt_value", ds_to_es.rt_value, reg_model[5]);
    @(negedge clk);
    es_fwd = '0;
endtask

task automatic test_stall_and_backpressure();
    @(negedge clk);
    es_fwd = make_fwd(1'b1, 1'b1, 5'd6, next_random());
    issue(enc_r(5'd1, 5'd6, 5'd17, 5'd0, fn_addu), 32'h0040_0030);
    repeat (3) begin
        @(posedge clk);
        check_equal("ds_to_es_valid", ds_to_es_valid, 1'b0);
        check_equal("ds_allowin", ds_allowin, 1'b0);
    end
    @(negedge clk);
    es_fwd = '0;
    await_output();
    check_equal("rt_value", ds_to_es.rt_value, reg_model[6]);

    @(negedge clk);
    es_allowin = 1'b0;
    issue(enc_i(op_addiu, 5'd2, 5'd18, 16'h0042), 32'h0040_0034);
    await_output();
    // a younger fetch item waits behind the held one
    @(negedge clk);
    fs_to_ds_valid = 1'b1;
    fs_to_ds       = make_fetch(1'b0, 5'd0, 32'h0, enc_i(op_ori, 5'd5, 5'd21, 16'h0bad),
                                32'h0040_00f0);
    repeat (3) begin
        @(posedge clk);
        check_equal("ds_to_es_valid", ds_to_es_valid, 1'b1);
        check_equal("ds_allowin", ds_allowin, 1'b0);
        check_equal("pc", ds_to_es.pc, 32'h0040_0034);
        check_equal("imm", ds_to_es.imm, 16'h0042);
        check_equal("dest", ds_to_es.dest, 5'd18);
        check_equal("rs_value", ds_to_es.rs_value, reg_model[2]);
    end
    @(negedge clk);
    fs_to_ds_valid = 1'b0;
    release_item();
    @(posedge clk);
    check_equal("ds_to_es_valid", ds_to_es_valid, 1'b0);

    @(negedge clk);
    es_allowin = 1'b0;
    issue(enc_i(op_ori, 5'd2, 5'd19, 16'h0001), 32'h0040_0038);
    await_output();
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush      = 1'b0;
    es_allowin = 1'b1;
    @(posedge clk);
    check_equal("ds_to_es_valid", ds_to_es_valid, 1'b0);
    check_equal("ds_allowin", ds_allowin, 1'b1);
endtask

task automatic branch_case(input logic [31:0] inst, input logic [31:0] pc,
                           input logic taken, input logic [31:0] target);
    issue(inst, pc);
    await_output();
    check_equal("br.op", br.op, 1'b1);
    check_equal("br.taken", br.taken, taken);
    check_equal("br.target", br.target, target);
endtask

task automatic test_branches();
    logic [31:0] pc;
    logic [4:0]  r;
    pc = 32'h0040_0100;
    write_reg(5'd20, next_random() | 32'h8000_0000);
    write_reg(5'd21, 32'h0);
    write_reg(5'd22, (next_random() & 32'h7fff_fff0) | 32'h1);
    branch_case(enc_i(op_beq, 5'd1, 5'd1, 16'hfffc), pc, 1'b1, branch_target(pc, 16'hfffc));
    branch_case(enc_i(op_beq, 5'd1, 5'd2, 16'h0010), pc, reg_model[1] == reg_model[2],
                branch_target(pc, 16'h0010));
    // negative, zero, then positive rs
    for (r = 5'd20; r <= 5'd22; r++) begin
        branch_case(enc_i(op_regimm, r, rt_bgez, 16'h0020), pc, !reg_model[r][31],
                    branch_target(pc, 16'h0020));
        branch_case(enc_i(op_bgtz, r, 5'd0, 16'h8001), pc,
                    !reg_model[r][31] && (reg_model[r] != 32'h0), branch_target(pc, 16'h8001));
    end
    pc = 32'h2fff_fffc;
    branch_case(enc_j(op_j, 26'h123_4567), pc, 1'b1, jump_target(pc, 26'h123_4567));
    pc = 32'h1000_0040;
    branch_case(enc_j(op_jal, 26'h2ab_cdef), pc, 1'b1, jump_target(pc, 26'h2ab_cdef));
    check_equal("dest", ds_to_es.dest, 5'd31);
    check_equal("src1_is_pc", ds_to_es.src1_is_pc, 1'b1);
    check_equal("src2_is_8", ds_to_es.src2_is_8, 1'b1);
    check_equal("gr_we", ds_to_es.gr_we, 1'b1);
    branch_case(enc_r(5'd22, 5'd0, 5'd0, 5'd0, fn_jr), pc, 1'b1, reg_model[22]);
endtask

task automatic test_exceptions();
    issue({6'h3f, 26'h0}, 32'h0040_0200);
    await_output();
    check_equal("ex", ds_to_es.ex, 1'b1);
    check_equal("exccode", ds_to_es.exccode, 5'd10);
    issue(enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_break), 32'h0040_0204);
    await_output();
    check_equal("ex", ds_to_es.ex, 1'b1);
    check_equal("exccode", ds_to_es.exccode, 5'd9);
    issue(enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_syscall), 32'h0040_0208);
    await_output();
    check_equal("ex", ds_to_es.ex, 1'b1);
    check_equal("exccode", ds_to_es.exccode, 5'd8);
    // fetch code must beat the reserved instruction code
    send(make_fetch(1'b1, 5'd4, 32'h0040_1003, {6'h3f, 26'h0}, 32'h0040_020c));
    await_output();
    check_equal("ex", ds_to_es.ex, 1'b1);
    check_equal("exccode", ds_to_es.exccode, 5'd4);
    check_equal("badvaddr", ds_to_es.badvaddr, 32'h0040_1003);
endtask

/* testbench/tb_decode_stage.sv */
module tb_decode_stage;
    import cpu_pkg::*;

    // rough cycle count of the whole test sequence
    localparam int planned_cycles = 160;
    localparam int wait_limit     = 20;
    localparam int cmp_w          = $bits(ds_to_es_t);

    logic      clk;
    logic      reset;
    logic      flush;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds;
    logic      ds_allowin;
    logic      es_allowin;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    fwd_src_t  es_fwd;
    fwd_src_t  ms_fwd;
    fwd_src_t  wb;
    br_t       br;

    logic [31:0] rng_state;
    logic [31:0] reg_model [32];

    decode_stage i_dut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds       (fs_to_ds),
        .ds_allowin     (ds_allowin),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .wb             (wb),
        .br             (br)
    );

    task automatic end_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_equal(input string name, input logic [cmp_w-1:0] actual,
                               input logic [cmp_w-1:0] expected);
        if (actual !== expected) begin
            $display("error: %s got %0h expected %0h", name, actual, expected);
            end_with_failure();
        end
    endtask

    `include "tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        #(planned_cycles * 10 * 2);
        $display("timeout: the test sequence did not finish in time");
        end_with_failure();
    end

    initial begin
        rng_state      = 32'h198ef650;
        reset          = 1'b1;
        flush          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds       = '0;
        es_allowin     = 1'b1;
        es_fwd         = '0;
        ms_fwd         = '0;
        wb             = '0;
        for (int i = 0; i < 32; i++) begin
            reg_model[i] = 32'h0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_and_regs();
        test_decode_fields();
        test_forwarding();
        test_stall_and_backpressure();
        test_branches();
        test_exceptions();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+testbench
common/cpu_pkg.sv
rtl/reg_file.sv
decode/inst_decoder.sv
decode/operand_bypass.sv
decode/branch_unit.sv
decode/decode_stage.sv
testbench/tb_decode_stage.sv
